// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = tb_ex_subsystem
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: files.f
source/rv32i_types.sv
source/alu.sv
source/cmp.sv
source/ctrl_decode.sv
source/execute.sv
source/pipe_reg.sv
source/ex_subsystem.sv
tests/tb_ex_subsystem.sv

// File: source/alu.sv
`timescale 1ns/10ps

module alu
import rv32i_types::*;
(
    input  alu_ops    aluop,
    input  rv32i_word a,
    input  rv32i_word b,
    output rv32i_word f
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only the low five bits count for RV32 shifts

    always_comb
    begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'b0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = $signed(a) >>> shamt;  // Sign bit fills from the left
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b;
        endcase
    end

endmodule

// File: source/cmp.sv
`timescale 1ns/10ps

module cmp
import rv32i_types::*;
(
    input  rv32i_word    a,
    input  rv32i_word    b,
    input  branch_funct3 cmpop,
    output logic         br_en
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    // Branch and set-less-than codes share the same three comparisons
    always_comb
    begin
        unique case (cmpop)
            beq:      br_en = eq;
            bne:      br_en = ~eq;
            blt, lt:  br_en = lt_s;
            bge:      br_en = ~lt_s;
            bltu, ltu: br_en = lt_u;
            bgeu:     br_en = ~lt_u;
        endcase
    end

endmodule

// File: source/ctrl_decode.sv
`timescale 1ns/10ps

module ctrl_decode
import rv32i_types::*;
(
    input  logic         in_valid,
    input  rv32i_word    instr,
    input  rv32i_word    pc,
    input  rv32i_word    rs1_out,
    input  rv32i_word    rs2_out,
    output ID_EX_stage_t id_rec
);

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic        known;     // Opcode is one the slice executes
    logic        has_rd;    // Instruction writes a destination register
    ex_ctrl_t    ctrl;

    assign opcode = rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];

    always_comb
    begin
        known            = 1'b1;
        has_rd           = 1'b1;
        ctrl.aluop       = alu_add;
        ctrl.cmpop       = beq;
        ctrl.alumux1_sel = alumux_rs1_out;
        ctrl.alumux2_sel = alumux_i_imm;
        ctrl.cmpmux_sel  = cmpmux_rs2_out;
        ctrl.marmux_sel  = marmux_pc_out;
        ctrl.is_branch   = 1'b0;

        case (opcode)
            op_lui:   ctrl.alumux2_sel = alumux_u_imm;  // rs1 is forced to zero below
            op_auipc:
            begin
                ctrl.alumux1_sel = alumux_pc_out;
                ctrl.alumux2_sel = alumux_u_imm;
            end
            op_jal:
            begin
                ctrl.alumux1_sel = alumux_pc_out;
                ctrl.alumux2_sel = alumux_j_imm;
            end
            op_jalr:  ctrl.alumux2_sel = alumux_i_imm;
            op_br:
            begin
                ctrl.alumux1_sel = alumux_pc_out;
                ctrl.alumux2_sel = alumux_b_imm;
                ctrl.cmpop       = branch_funct3'(funct3);
                ctrl.is_branch   = 1'b1;
                has_rd           = 1'b0;
                known            = (funct3[2:1] != 2'b01);  // 010 and 011 are not branches
            end
            op_load:  ctrl.marmux_sel = marmux_alu_out;
            op_store:
            begin
                ctrl.alumux2_sel = alumux_s_imm;
                ctrl.marmux_sel  = marmux_alu_out;
                has_rd           = 1'b0;
            end
            op_imm:
            begin
                // Only srai carries funct7 bit 5, the other immediates use it as data
                ctrl.aluop      = alu_ops'({(funct3 == 3'b101) & instr[30], funct3});
                ctrl.cmpop      = branch_funct3'(funct3);
                ctrl.cmpmux_sel = cmpmux_i_imm;
            end
            op_reg:
            begin
                ctrl.aluop       = alu_ops'({instr[30], funct3});
                ctrl.cmpop       = branch_funct3'(funct3);
                ctrl.alumux2_sel = alumux_rs2_out;
            end
            default:  known = 1'b0;  // Anything else becomes a bubble
        endcase
    end

    assign id_rec.ctrl_wd.valid     = in_valid & known;
    assign id_rec.ctrl_wd.opcode    = opcode;
    assign id_rec.ctrl_wd.funct3    = funct3;
    assign id_rec.ctrl_wd.pc        = pc;
    assign id_rec.ctrl_wd.ex_ctrlwd = ctrl;

    // lui adds u_imm to zero, so the rs1 operand is cleared here
    assign id_rec.rs1_out = (opcode == op_lui) ? '0 : rs1_out;
    assign id_rec.rs2_out = rs2_out;

    assign id_rec.i_imm = {{21{instr[31]}}, instr[30:20]};
    assign id_rec.s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign id_rec.b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign id_rec.u_imm = {instr[31:12], 12'h000};
    assign id_rec.j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign id_rec.rd    = has_rd ? instr[11:7] : 5'd0;

endmodule

// File: source/ex_subsystem.sv
`timescale 1ns/10ps

module ex_subsystem
import rv32i_types::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          in_valid,
    input  rv32i_word     instr,
    input  rv32i_word     pc,
    input  rv32i_word     rs1_out,
    input  rv32i_word     rs2_out,
    output EX_MEM_stage_t ex_mem,
    output pcmux_sel_t    pcmux_sel,
    output rv32i_word     redirect_target
);

    ID_EX_stage_t  id_rec;
    ID_EX_stage_t  ex_rec;
    EX_MEM_stage_t ex_rec_out;
    logic          squash;

    ctrl_decode u_decode (
        .in_valid (in_valid),
        .instr    (instr),
        .pc       (pc),
        .rs1_out  (rs1_out),
        .rs2_out  (rs2_out),
        .id_rec   (id_rec)
    );

    // Squash from EX kills the instruction entering ID/EX in the same cycle
    pipe_reg #(
        .payload_t (ID_EX_stage_t)
    ) u_id_ex (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (id_rec),
        .squash (squash),
        .q      (ex_rec)
    );

    execute u_execute (
        .ex_in     (ex_rec),
        .ex_out    (ex_rec_out),
        .pcmux_sel (pcmux_sel),
        .squash    (squash)
    );

    pipe_reg #(
        .payload_t (EX_MEM_stage_t)
    ) u_ex_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (ex_rec_out),
        .squash (1'b0),  // The redirecting instruction itself must retire
        .q      (ex_mem)
    );

    assign redirect_target = ex_rec_out.alu_out;

endmodule

// File: source/execute.sv
`timescale 1ns/10ps

module execute
import rv32i_types::*;
(
    input  ID_EX_stage_t  ex_in,
    output EX_MEM_stage_t ex_out,
    output pcmux_sel_t    pcmux_sel,
    output logic          squash
);

    ex_ctrl_t  ctrl;
    rv32i_word alumux1_out;
    rv32i_word alumux2_out;
    rv32i_word cmpmux_out;
    rv32i_word alu_out;
    rv32i_word marmux_out;
    logic      br_en;
    logic      is_jal;
    logic      is_jalr;
    logic      redirect;

    assign ctrl    = ex_in.ctrl_wd.ex_ctrlwd;
    assign is_jal  = (ex_in.ctrl_wd.opcode == op_jal);
    assign is_jalr = (ex_in.ctrl_wd.opcode == op_jalr);

    alu u_alu (
        .aluop (ctrl.aluop),
        .a     (alumux1_out),
        .b     (alumux2_out),
        .f     (alu_out)
    );

    cmp u_cmp (
        .a     (ex_in.rs1_out),
        .b     (cmpmux_out),
        .cmpop (ctrl.cmpop),
        .br_en (br_en)
    );

    always_comb
    begin
        alumux1_out = (ctrl.alumux1_sel == alumux_pc_out) ? ex_in.ctrl_wd.pc : ex_in.rs1_out;

        case (ctrl.alumux2_sel)
            alumux_u_imm:   alumux2_out = ex_in.u_imm;
            alumux_b_imm:   alumux2_out = ex_in.b_imm;
            alumux_s_imm:   alumux2_out = ex_in.s_imm;
            alumux_j_imm:   alumux2_out = ex_in.j_imm;
            alumux_rs2_out: alumux2_out = ex_in.rs2_out;
            default:        alumux2_out = ex_in.i_imm;
        endcase

        cmpmux_out = (ctrl.cmpmux_sel == cmpmux_i_imm) ? ex_in.i_imm : ex_in.rs2_out;
        marmux_out = (ctrl.marmux_sel == marmux_alu_out) ? alu_out : ex_in.ctrl_wd.pc;
    end

    // Any jump, or a branch whose comparison holds, leaves the sequential path
    assign redirect = is_jal | is_jalr | (ctrl.is_branch & br_en);
    assign squash   = ex_in.ctrl_wd.valid & redirect;

    always_comb
    begin
        pcmux_sel = pcmux_pc_plus4;
        if (ex_in.ctrl_wd.valid)
        begin
            if (is_jalr)
                pcmux_sel = pcmux_alu_mod2;  // Fetch clears bit 0 of the target
            else if (is_jal || (ctrl.is_branch && br_en))
                pcmux_sel = pcmux_alu_out;
        end
    end

    assign ex_out.ctrl_wd      = ex_in.ctrl_wd;
    assign ex_out.cmp_out      = br_en;
    assign ex_out.alu_out      = alu_out;
    assign ex_out.mar          = marmux_out;
    assign ex_out.mem_data_out = ex_in.rs2_out << {marmux_out[1:0], 3'b000};  // Byte lane shift
    assign ex_out.u_imm        = ex_in.u_imm;
    assign ex_out.rd           = ex_in.rd;

    bubble_is_sequential: assert final (ex_in.ctrl_wd.valid || pcmux_sel == pcmux_pc_plus4)
        else $error("Invalid EX record selected a non-sequential PC");

    squash_matches_sel: assert final (squash == (pcmux_sel != pcmux_pc_plus4))
        else $error("Squash disagrees with the next-PC select");

endmodule

// File: source/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg
import rv32i_types::*;
#(
    parameter type payload_t = ID_EX_stage_t
)
(
    input  logic     clk,
    input  logic     arst_n,
    input  payload_t d,
    input  logic     squash,
    output payload_t q
);

    payload_t payload_q;
    logic     valid_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= d.ctrl_wd.valid & ~squash;  // Wrong-path record becomes a bubble
    end

    always_ff @(posedge clk)
    begin
        payload_q <= d;
    end

    // Valid is taken from the reset flop and not from the stored copy
    always_comb
    begin
        q               = payload_q;
        q.ctrl_wd.valid = valid_q;
    end

    squash_kills_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        squash |=> !q.ctrl_wd.valid
    ) else $error("Record captured during squash left the register valid");

endmodule

// File: source/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] rv32i_word;

    // Base opcodes of the RV32I instruction formats handled by the slice
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,  // U-type, load upper immediate
        op_auipc = 7'b0010111,  // U-type, add upper immediate to PC
        op_jal   = 7'b1101111,  // J-type
        op_jalr  = 7'b1100111,  // I-type jump through register
        op_br    = 7'b1100011,  // B-type conditional branch
        op_load  = 7'b0000011,  // I-type load
        op_store = 7'b0100011,  // S-type store
        op_imm   = 7'b0010011,  // I-type ALU
        op_reg   = 7'b0110011   // R-type ALU
    } rv32i_opcode;

    // Encoded as {funct7[5], funct3} so R-type decode is a plain copy
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_ops;

    // Branch funct3 values, with the two unused codes taken by set-less-than
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        lt   = 3'b010,  // Same code as slt/slti
        ltu  = 3'b011,  // Same code as sltu/sltiu
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3;

    typedef enum logic {
        alumux_rs1_out = 1'b0,
        alumux_pc_out  = 1'b1
    } alumux_sel1_t;

    typedef enum logic [2:0] {
        alumux_i_imm   = 3'b000,
        alumux_u_imm   = 3'b001,
        alumux_b_imm   = 3'b010,
        alumux_s_imm   = 3'b011,
        alumux_j_imm   = 3'b100,
        alumux_rs2_out = 3'b101
    } alumux_sel2_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef enum logic {
        marmux_pc_out  = 1'b0,
        marmux_alu_out = 1'b1
    } marmux_sel_t;

    // Next-PC select handed back to fetch
    typedef enum logic [1:0] {
        pcmux_pc_plus4 = 2'b00,
        pcmux_alu_out  = 2'b01,
        pcmux_alu_mod2 = 2'b10  // ALU result with bit 0 cleared, for jalr
    } pcmux_sel_t;

    // Selects consumed by the execute stage
    typedef struct packed {
        alu_ops       aluop;
        branch_funct3 cmpop;
        alumux_sel1_t alumux1_sel;
        alumux_sel2_t alumux2_sel;
        cmpmux_sel_t  cmpmux_sel;
        marmux_sel_t  marmux_sel;
        logic         is_branch;
    } ex_ctrl_t;

    typedef struct packed {
        logic         valid;
        rv32i_opcode  opcode;
        logic [2:0]   funct3;
        rv32i_word    pc;
        ex_ctrl_t     ex_ctrlwd;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t   ctrl_wd;
        rv32i_word    rs1_out;
        rv32i_word    rs2_out;
        rv32i_word    i_imm;
        rv32i_word    s_imm;
        rv32i_word    b_imm;
        rv32i_word    u_imm;
        rv32i_word    j_imm;
        logic [4:0]   rd;
    } ID_EX_stage_t;

    typedef struct packed {
        ctrl_word_t   ctrl_wd;
        logic         cmp_out;
        rv32i_word    alu_out;
        rv32i_word    mar;
        rv32i_word    mem_data_out;  // Store data already aligned to the byte lane
        rv32i_word    u_imm;
        logic [4:0]   rd;
    } EX_MEM_stage_t;

endpackage

// File: tests/tb_ex_subsystem.sv
`timescale 1ns/10ps

module tb_ex_subsystem
import rv32i_types::*;
();

    typedef struct packed {
        EX_MEM_stage_t rec;
        pcmux_sel_t    sel;
        logic          chk_cmp;  // Compare result only matters for branches
        logic          chk_mem;  // Address and aligned data only matter for stores
        logic [31:0]   due;      // Cycle count at which the record is due at ex_mem
    } expect_t;

    localparam logic [2:0] br_codes [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic          clk;
    logic          arst_n;
    logic          in_valid;
    rv32i_word     instr;
    rv32i_word     pc;
    rv32i_word     rs1_out;
    rv32i_word     rs2_out;
    EX_MEM_stage_t ex_mem;
    pcmux_sel_t    pcmux_sel;
    rv32i_word     redirect_target;

    logic [31:0]   rng_state;
    logic [31:0]   cycle_cnt;
    logic          prev_redirect;  // Instruction driven in the last cycle left the sequential path
    expect_t       exp_q [$];
    int            err_count;
    int            err_mark;
    int            tests_passed;
    int            tests_failed;

    ex_subsystem u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_valid        (in_valid),
        .instr           (instr),
        .pc              (pc),
        .rs1_out         (rs1_out),
        .rs2_out         (rs2_out),
        .ex_mem          (ex_mem),
        .pcmux_sel       (pcmux_sel),
        .redirect_target (redirect_target)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic rv32i_word alu_result(input logic [2:0] f3, input logic alt,
                                             input rv32i_word a, input rv32i_word b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:
            begin
                if (alt)
                    return $signed(a) >>> b[4:0];  // Arithmetic shift keeps the sign
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input rv32i_word a,
                                          input rv32i_word b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Expected EX/MEM record and next-PC select from the instruction fields alone
    function automatic expect_t ref_execute(input rv32i_word ins, input rv32i_word pc_v,
                                            input rv32i_word a, input rv32i_word b);
        expect_t    e;
        logic [2:0] f3;
        rv32i_word  i_imm;
        e = '0;
        f3 = ins[14:12];
        i_imm = {{20{ins[31]}}, ins[31:20]};
        e.rec.ctrl_wd.valid  = 1'b1;
        e.rec.ctrl_wd.opcode = rv32i_opcode'(ins[6:0]);
        e.rec.ctrl_wd.funct3 = f3;
        e.rec.ctrl_wd.pc     = pc_v;
        e.rec.u_imm          = {ins[31:12], 12'h000};
        e.rec.rd             = ins[11:7];
        e.sel                = pcmux_pc_plus4;
        case (rv32i_opcode'(ins[6:0]))
            op_reg:   e.rec.alu_out = alu_result(f3, ins[30], a, b);
            op_imm:   e.rec.alu_out = alu_result(f3, ins[30] && f3 == 3'b101, a, i_imm);
            op_lui:   e.rec.alu_out = e.rec.u_imm;
            op_auipc: e.rec.alu_out = pc_v + e.rec.u_imm;
            op_jal:
            begin
                e.rec.alu_out = pc_v + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                        ins[30:21], 1'b0};
                e.sel         = pcmux_alu_out;
            end
            op_jalr:
            begin
                e.rec.alu_out = a + i_imm;
                e.sel         = pcmux_alu_mod2;
            end
            op_br:
            begin
                e.rec.alu_out = pc_v + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                e.rec.cmp_out = branch_taken(f3, a, b);
                e.rec.rd      = 5'd0;
                e.chk_cmp     = 1'b1;
                if (e.rec.cmp_out)
                    e.sel = pcmux_alu_out;
            end
            default:
            begin
                e.rec.alu_out      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                e.rec.mar          = e.rec.alu_out;
                e.rec.mem_data_out = b << {e.rec.mar[1:0], 3'b000};
                e.rec.rd           = 5'd0;
                e.chk_mem          = 1'b1;
            end
        endcase
        return e;
    endfunction

    // Kinds 0 to 7 are R, I-ALU, LUI, AUIPC, branch, JAL, JALR and store
    function automatic rv32i_word make_instr(input int kind, input rv32i_word r,
                                             input logic [2:0] f3_br);
        rv32i_word ins;
        ins = r;
        case (kind)
            0:
            begin
                ins[6:0]   = op_reg;
                ins[31:25] = {1'b0, r[30] & (r[14:12] == 3'b000 || r[14:12] == 3'b101), 5'b0};
            end
            1:
            begin
                ins[6:0] = op_imm;
                if (r[14:12] == 3'b001 || r[14:12] == 3'b101)
                    ins[31:25] = {1'b0, r[30] & r[14], 5'b0};  // Legal shift encodings only
            end
            2:       ins[6:0] = op_lui;
            3:       ins[6:0] = op_auipc;
            4:
            begin
                ins[6:0]   = op_br;
                ins[14:12] = f3_br;
            end
            5:       ins[6:0] = op_jal;
            6:
            begin
                ins[6:0]   = op_jalr;
                ins[14:12] = 3'b000;
            end
            default:
            begin
                ins[6:0] = op_store;
                ins[14]  = 1'b0;
            end
        endcase
        return ins;
    endfunction

    task automatic issue(input int kind, input logic [2:0] f3_br, input logic same_regs);
        rv32i_word r;
        rv32i_word ins;
        rv32i_word pc_v;
        rv32i_word a;
        rv32i_word b;
        expect_t   e;
        next_rand(r);
        ins = make_instr(kind, r, f3_br);
        next_rand(pc_v);
        pc_v[1:0] = 2'b00;
        next_rand(a);
        next_rand(b);
        if (same_regs)
            b = a;
        e = ref_execute(ins, pc_v, a, b);
        @(posedge clk);
        in_valid <= 1'b1;
        instr    <= ins;
        pc       <= pc_v;
        rs1_out  <= a;
        rs2_out  <= b;
        e.due = cycle_cnt + 3;  // Reaches ex_mem at the second edge from this one
        if (!prev_redirect)
            exp_q.push_back(e);
        prev_redirect = !prev_redirect && (e.sel != pcmux_pc_plus4);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            in_valid <= 1'b0;
            prev_redirect = 1'b0;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Run aborted: %s", reason);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() > 0 && waited < 16)
        begin
            idle(1);
            waited++;
        end
        if (exp_q.size() > 0)
            abort_run($sformatf("expected record for pc %h never arrived",
                                exp_q[0].rec.ctrl_wd.pc));
    endtask

    task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_pcmux(input pcmux_sel_t got, input pcmux_sel_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t pcmux_sel got %0d expected %0d", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_ex_mem(input EX_MEM_stage_t got, input EX_MEM_stage_t exp,
                                input logic chk_cmp, input logic chk_mem);
        check_word("ex_mem.pc", got.ctrl_wd.pc, exp.ctrl_wd.pc);
        check_word("ex_mem.opcode", {25'b0, got.ctrl_wd.opcode}, {25'b0, exp.ctrl_wd.opcode});
        check_word("ex_mem.funct3", {29'b0, got.ctrl_wd.funct3}, {29'b0, exp.ctrl_wd.funct3});
        check_word("ex_mem.alu_out", got.alu_out, exp.alu_out);
        check_word("ex_mem.u_imm", got.u_imm, exp.u_imm);
        check_word("ex_mem.rd", {27'b0, got.rd}, {27'b0, exp.rd});
        if (chk_cmp)
            check_word("ex_mem.cmp_out", {31'b0, got.cmp_out}, {31'b0, exp.cmp_out});
        if (chk_mem)
        begin
            check_word("ex_mem.mar", got.mar, exp.mar);
            check_word("ex_mem.mem_data_out", got.mem_data_out, exp.mem_data_out);
        end
    endtask

    // Outputs are sampled half a cycle after the edge that moved them
    always @(negedge clk)
    begin : compare_outputs
        expect_t e;
        if (exp_q.size() > 0 && exp_q[0].due < cycle_cnt)
        begin
            $display("Error at %0t: record for pc %h never arrived at ex_mem",
                     $time, exp_q[0].rec.ctrl_wd.pc);
            err_count++;
            void'(exp_q.pop_front());
        end
        if (ex_mem.ctrl_wd.valid)
        begin
            if (exp_q.size() == 0 || exp_q[0].due != cycle_cnt)
            begin
                $display("Error at %0t: unexpected record for pc %h at ex_mem",
                         $time, ex_mem.ctrl_wd.pc);
                err_count++;
            end
            else
            begin
                e = exp_q.pop_front();
                check_ex_mem(ex_mem, e.rec, e.chk_cmp, e.chk_mem);
            end
        end
        if (exp_q.size() > 0 && exp_q[0].due == cycle_cnt + 1)
        begin
            check_pcmux(pcmux_sel, exp_q[0].sel);  // Front record sits in EX now
            if (exp_q[0].sel != pcmux_pc_plus4)
                check_word("redirect_target", redirect_target, exp_q[0].rec.alu_out);
        end
        else
            check_pcmux(pcmux_sel, pcmux_pc_plus4);
    end

    task automatic end_test(input string name);
        int errs;
        drain();
        errs = err_count - err_mark;
        err_mark = err_count;
        if (errs == 0)
            tests_passed++;
        else
            tests_failed++;
        $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    initial
    begin
        #100000;
        abort_run("watchdog expired before the test sequence finished");
    end

    initial
    begin : main_sequence
        rv32i_word r;
        clk           = 1'b0;
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        instr         = '0;
        pc            = '0;
        rs1_out       = '0;
        rs2_out       = '0;
        rng_state     = 32'h84b;
        cycle_cnt     = '0;
        prev_redirect = 1'b0;
        err_count     = 0;
        err_mark      = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        idle(4);
        end_test("reset");
        repeat (40)
        begin
            next_rand(r);
            issue(int'(r[1:0]), 3'b000, 1'b0);
        end
        end_test("alu");
        for (int k = 0; k < 24; k++)
        begin
            issue(4, br_codes[k % 6], k >= 12);  // Second half compares equal operands
            idle(1);
        end
        end_test("branch");
        for (int k = 0; k < 12; k++)
        begin
            issue(5 + (k % 2), 3'b000, 1'b0);
            idle(1);
        end
        end_test("jump");
        repeat (16) issue(7, 3'b000, 1'b0);
        end_test("store");
        for (int k = 0; k < 8; k++)
        begin
            issue((k < 4) ? 5 : 4, 3'b000, 1'b1);  // Jal in the first four rounds and a taken beq later
            issue(0, 3'b000, 1'b0);               // On the wrong path and never retires
            issue(1, 3'b000, 1'b0);
            idle(1);
        end
        end_test("squash");
        repeat (200)
        begin
            next_rand(r);
            issue(int'(r[2:0]), br_codes[int'(r[5:3]) % 6], r[6] & r[7]);
            if (r[9:8] == 2'b00)
                idle(1);
        end
        end_test("random");
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
